//--- common/icache_pkg.sv
//////////////////////////////////////////////////////////////////////
// cache geometry and fetch address layout for the two-way icache
// every rtl file reaches these by icache_pkg:: scoped names
// the address union gives a raw view and a tag/index/offset view
//////////////////////////////////////////////////////////////////////

package icache_pkg;

  // core fetch address and instruction word
  localparam int ADDR_W     = 16;
  localparam int WORD_W     = 32;
  // one line carries four instruction words
  localparam int LINE_W     = 128;

  // two ways, sixteen sets
  localparam int NUM_WAYS   = 2;
  localparam int NUM_SETS   = 16;
  localparam int WAY_IDX_W  = $clog2(NUM_WAYS);

  // address split, offset is a byte offset within the line
  localparam int OFFSET_W   = 4;
  localparam int INDEX_W    = 4;
  localparam int TAG_W      = 8;
  // word select comes from offset bits 3..2
  localparam int WORD_SEL_W = 2;

  // replacement lfsr length
  localparam int LFSR_W     = 4;

  // field view of a fetch address, msb first
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } icache_addr_fields_t;

  // same word seen raw or split into fields
  typedef union packed {
    logic [ADDR_W-1:0]   raw;
    icache_addr_fields_t fields;
  } icache_addr_u;

endpackage

//--- icache/icache_tag_array.sv
//////////////////////////////////////////////////////////////////////
// tag and valid storage for both ways of the icache
// a read registers tags and valid bits, hit and victim way follow
// one cycle later; a write fills the victim way, clr wipes a set
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module icache_tag_array (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [icache_pkg::INDEX_W-1:0]  index_i,
  input  logic                            rd_en_i,
  input  logic                            wr_en_i,
  input  logic                            clr_i,
  input  logic [icache_pkg::TAG_W-1:0]    tag_i,
  output logic [icache_pkg::NUM_WAYS-1:0] hit_o,
  output logic [icache_pkg::NUM_WAYS-1:0] repl_way_o
);

  // storage
  logic [icache_pkg::TAG_W-1:0]    tag_mem [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];
  logic [icache_pkg::NUM_WAYS-1:0] valid_q [icache_pkg::NUM_SETS];

  // registered read side
  logic [icache_pkg::TAG_W-1:0]    rd_tag_q [icache_pkg::NUM_WAYS];
  logic [icache_pkg::NUM_WAYS-1:0] rd_valid_q;
  logic [icache_pkg::TAG_W-1:0]    cmp_tag_q;

  // replacement
  logic [icache_pkg::LFSR_W-1:0]   lfsr_q;
  logic                            all_valid;

  //////////////////////////////////////////////////////////////////////
  // arrays
  //////////////////////////////////////////////////////////////////////

  // tags only ever land in the victim way
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
        if (repl_way_o[w]) begin
          tag_mem[w][index_i] <= tag_i;
        end
      end
    end
  end

  // valid bits, flush clear wins over a fill
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (clr_i) begin
      valid_q[index_i] <= '0;
    end else if (wr_en_i) begin
      valid_q[index_i] <= valid_q[index_i] | repl_way_o;
    end
  end

  // synchronous read, held until the next read
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
        rd_tag_q[w] <= tag_mem[w][index_i];
      end
      rd_valid_q <= valid_q[index_i];
      cmp_tag_q  <= tag_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // compare and victim choice
  //////////////////////////////////////////////////////////////////////

  assign all_valid = &rd_valid_q;

  always_comb begin
    hit_o      = '0;
    repl_way_o = '0;
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      hit_o[w] = rd_valid_q[w] & (rd_tag_q[w] == cmp_tag_q);
    end
    // lowest invalid way first, scanning down keeps the lowest
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (!rd_valid_q[w]) begin
        repl_way_o    = '0;
        repl_way_o[w] = 1'b1;
      end
    end
    // set full, pick at random
    if (all_valid) begin
      repl_way_o[lfsr_q[icache_pkg::WAY_IDX_W-1:0]] = 1'b1;
    end
  end

  // x^4 + x^3 + 1, steps only when a full set is refilled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 4'b1001;
    end else if (wr_en_i && all_valid) begin
      lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
    end
  end

endmodule

//--- icache/icache_data_array.sv
//////////////////////////////////////////////////////////////////////
// line storage for both ways of the icache
// a read returns the selected word of every way one cycle later,
// a write stores a whole returned line into one way
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module icache_data_array (
  input  logic                                                  clk_i,
  input  logic [icache_pkg::INDEX_W-1:0]                        index_i,
  input  logic                                                  rd_en_i,
  input  logic                                                  wr_en_i,
  input  logic [icache_pkg::NUM_WAYS-1:0]                       wr_way_i,
  input  logic [icache_pkg::WORD_SEL_W-1:0]                     word_sel_i,
  input  logic [icache_pkg::LINE_W-1:0]                         line_i,
  output logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::WORD_W-1:0] words_o
);

  // one line per way and set
  logic [icache_pkg::LINE_W-1:0] line_mem [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];

  always_ff @(posedge clk_i) begin
    // fill, wr_way_i is one-hot
    if (wr_en_i) begin
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
        if (wr_way_i[w]) begin
          line_mem[w][index_i] <= line_i;
        end
      end
    end
    // every way reads out the same word position
    // the controller picks the hitting way afterwards
    if (rd_en_i) begin
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
        words_o[w] <= line_mem[w][index_i][word_sel_i * icache_pkg::WORD_W +: icache_pkg::WORD_W];
      end
    end
  end

endmodule

//--- icache/icache_ctrl.sv
//////////////////////////////////////////////////////////////////////
// icache controller: fetch fsm, set-by-set flush and refill handling
// drives index, enables and tag of both arrays, merges per-way
// words using the hit vector and answers the core one word at a time
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module icache_ctrl (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  flush_i,
  // core fetch side
  input  logic                                                  req_valid_i,
  input  icache_pkg::icache_addr_u                              req_addr_i,
  output logic                                                  req_ready_o,
  output logic                                                  rsp_valid_o,
  output logic [icache_pkg::WORD_W-1:0]                         rsp_data_o,
  input  logic                                                  rsp_ready_i,
  // memory side
  output logic                                                  mem_req_valid_o,
  output logic [icache_pkg::ADDR_W-1:0]                         mem_req_addr_o,
  input  logic                                                  mem_req_ready_i,
  input  logic                                                  mem_rtrn_valid_i,
  input  logic [icache_pkg::LINE_W-1:0]                         mem_rtrn_line_i,
  output logic                                                  miss_o,
  // array control
  output logic [icache_pkg::INDEX_W-1:0]                        index_o,
  output logic                                                  rd_en_o,
  output logic                                                  wr_en_o,
  output logic                                                  clr_o,
  output logic [icache_pkg::TAG_W-1:0]                          tag_o,
  output logic [icache_pkg::WORD_SEL_W-1:0]                     word_sel_o,
  output logic [icache_pkg::NUM_WAYS-1:0]                       wr_way_o,
  // array results
  input  logic [icache_pkg::NUM_WAYS-1:0]                       hit_i,
  input  logic [icache_pkg::NUM_WAYS-1:0]                       repl_way_i,
  input  logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::WORD_W-1:0] words_i
);

  typedef enum logic [2:0] {FLUSH, IDLE, LOOKUP, MISS_REQ, MISS_WAIT, RESPOND} state_e;

  state_e                                state_q, state_d;
  logic [icache_pkg::INDEX_W-1:0]        flush_cnt_q;
  logic                                  flush_pend_q;
  icache_pkg::icache_addr_u              addr_q;
  icache_pkg::icache_addr_u              cur_addr;
  logic [icache_pkg::NUM_WAYS-1:0]       repl_way_q;
  logic [icache_pkg::WORD_W-1:0]         rsp_data_q;
  logic [icache_pkg::WORD_W-1:0]         hit_word;
  logic [icache_pkg::WORD_W-1:0]         fill_word;
  logic                                  req_fire;
  logic                                  fill_fire;

  //////////////////////////////////////////////////////////////////////
  // handshakes and array control
  //////////////////////////////////////////////////////////////////////

  // one request in flight, accept only in IDLE
  assign req_ready_o = (state_q == IDLE);
  assign req_fire    = req_ready_o & req_valid_i;
  assign fill_fire   = (state_q == MISS_WAIT) & mem_rtrn_valid_i;

  // the lookup reads with the incoming address, everything later uses the latched one
  assign cur_addr    = (state_q == IDLE) ? req_addr_i : addr_q;
  assign index_o     = (state_q == FLUSH) ? flush_cnt_q : cur_addr.fields.index;
  assign tag_o       = cur_addr.fields.tag;
  assign word_sel_o  = cur_addr.fields.offset[icache_pkg::OFFSET_W-1 -: icache_pkg::WORD_SEL_W];
  assign rd_en_o     = req_fire;
  // returns are taken whenever they show up in MISS_WAIT
  assign wr_en_o     = fill_fire;
  assign clr_o       = (state_q == FLUSH);
  assign wr_way_o    = repl_way_q;

  // line-aligned refill address
  assign mem_req_valid_o = (state_q == MISS_REQ);
  assign mem_req_addr_o  = {addr_q.fields.tag, addr_q.fields.index,
                            {icache_pkg::OFFSET_W{1'b0}}};
  // perf counter pulse, one per refill handshake
  assign miss_o          = mem_req_valid_o & mem_req_ready_i;

  assign rsp_valid_o = (state_q == RESPOND);
  assign rsp_data_o  = rsp_data_q;

  // word of the hitting way, hit vector is at most one-hot
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      if (hit_i[w]) begin
        hit_word = words_i[w];
      end
    end
  end

  // requested word straight out of the returned line
  assign fill_word = mem_rtrn_line_i[word_sel_o * icache_pkg::WORD_W +: icache_pkg::WORD_W];

  //////////////////////////////////////////////////////////////////////
  // fsm
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // one set per cycle, leave after the last one
      FLUSH: begin
        if (flush_cnt_q == icache_pkg::NUM_SETS - 1) begin
          state_d = IDLE;
        end
      end
      // a request taken together with a flush pulse keeps the flush pending
      IDLE: begin
        if (req_fire) begin
          state_d = LOOKUP;
        end else if (flush_i || flush_pend_q) begin
          state_d = FLUSH;
        end
      end
      LOOKUP: begin
        state_d = (|hit_i) ? RESPOND : MISS_REQ;
      end
      MISS_REQ: begin
        if (mem_req_ready_i) begin
          state_d = MISS_WAIT;
        end
      end
      MISS_WAIT: begin
        if (mem_rtrn_valid_i) begin
          state_d = RESPOND;
        end
      end
      // run a remembered flush right after the response leaves
      RESPOND: begin
        if (rsp_ready_i) begin
          state_d = (flush_i || flush_pend_q) ? FLUSH : IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  // control state, reset starts with a full flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= FLUSH;
      flush_cnt_q  <= '0;
      flush_pend_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // counter wraps back to zero on the last set
      if (state_q == FLUSH) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
      flush_pend_q <= (state_q == FLUSH) ? 1'b0 : (flush_pend_q | flush_i);
    end
  end

  // payload registers
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      addr_q <= req_addr_i;
    end
    // victim is fixed before the fill goes out
    if (state_q == LOOKUP) begin
      repl_way_q <= repl_way_i;
    end
    if (state_q == LOOKUP && |hit_i) begin
      rsp_data_q <= hit_word;
    end else if (fill_fire) begin
      rsp_data_q <= fill_word;
    end
  end

endmodule

//--- design/icache_top.sv
//////////////////////////////////////////////////////////////////////
// two-way set-associative instruction cache, top level
// core fetch port in, single-beat line refill port out
// the controller steers both arrays, which work side by side
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module icache_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,
  input  logic                            req_valid_i,
  input  logic [icache_pkg::ADDR_W-1:0]   req_addr_i,
  output logic                            req_ready_o,
  output logic                            rsp_valid_o,
  output logic [icache_pkg::WORD_W-1:0]   rsp_data_o,
  input  logic                            rsp_ready_i,
  output logic                            mem_req_valid_o,
  output logic [icache_pkg::ADDR_W-1:0]   mem_req_addr_o,
  input  logic                            mem_req_ready_i,
  input  logic                            mem_rtrn_valid_i,
  input  logic [icache_pkg::LINE_W-1:0]   mem_rtrn_line_i,
  output logic                            miss_o
);

  // fetch address, field view used by the controller
  icache_pkg::icache_addr_u                                req_addr;

  // controller to arrays
  logic [icache_pkg::INDEX_W-1:0]                          index;
  logic                                                    rd_en;
  logic                                                    wr_en;
  logic                                                    clr;
  logic [icache_pkg::TAG_W-1:0]                            tag;
  logic [icache_pkg::WORD_SEL_W-1:0]                       word_sel;
  logic [icache_pkg::NUM_WAYS-1:0]                         wr_way;

  // arrays to controller
  logic [icache_pkg::NUM_WAYS-1:0]                         hit;
  logic [icache_pkg::NUM_WAYS-1:0]                         repl_way;
  logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::WORD_W-1:0] words;

  assign req_addr.raw = req_addr_i;

  icache_ctrl icache_ctrl_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .req_valid_i      (req_valid_i),
    .req_addr_i       (req_addr),
    .req_ready_o      (req_ready_o),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_data_o       (rsp_data_o),
    .rsp_ready_i      (rsp_ready_i),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_rtrn_valid_i (mem_rtrn_valid_i),
    .mem_rtrn_line_i  (mem_rtrn_line_i),
    .miss_o           (miss_o),
    .index_o          (index),
    .rd_en_o          (rd_en),
    .wr_en_o          (wr_en),
    .clr_o            (clr),
    .tag_o            (tag),
    .word_sel_o       (word_sel),
    .wr_way_o         (wr_way),
    .hit_i            (hit),
    .repl_way_i       (repl_way),
    .words_i          (words)
  );

  icache_tag_array icache_tag_array_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .index_i    (index),
    .rd_en_i    (rd_en),
    .wr_en_i    (wr_en),
    .clr_i      (clr),
    .tag_i      (tag),
    .hit_o      (hit),
    .repl_way_o (repl_way)
  );

  // refill line comes straight from the memory return
  icache_data_array icache_data_array_i (
    .clk_i      (clk_i),
    .index_i    (index),
    .rd_en_i    (rd_en),
    .wr_en_i    (wr_en),
    .wr_way_i   (wr_way),
    .word_sel_i (word_sel),
    .line_i     (mem_rtrn_line_i),
    .words_o    (words)
  );

endmodule

//--- verification/icache_checker.sv
//////////////////////////////////////////////////////////////////////
// checker for the icache testbench
// samples the DUT ports on the rising edge, tracks the open fetch,
// keeps a model of resident tags and raises timeout at the limit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module icache_checker (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  logic                          req_valid_i,
  input  logic [icache_pkg::ADDR_W-1:0] req_addr_i,
  input  logic                          req_ready_i,
  input  logic [icache_pkg::WORD_W-1:0] exp_word_i,
  input  logic                          rsp_valid_i,
  input  logic [icache_pkg::WORD_W-1:0] rsp_data_i,
  input  logic                          rsp_ready_i,
  input  logic                          mem_req_valid_i,
  input  logic [icache_pkg::ADDR_W-1:0] mem_req_addr_i,
  input  logic                          mem_req_ready_i,
  input  logic                          miss_i,
  input  int unsigned                   cycle_limit_i,
  output int unsigned                   chk_cnt_o,
  output int unsigned                   err_cnt_o,
  output logic                          timeout_o
);

  // tags known for certain to be resident in two slots per set
  logic [icache_pkg::TAG_W-1:0]  kn_tag [icache_pkg::NUM_SETS][2];
  logic                          kn_vld [icache_pkg::NUM_SETS][2];
  // both ways filled and one slot may be unknown after a random eviction
  logic                          set_full [icache_pkg::NUM_SETS];

  int unsigned                   cyc = 0;
  int unsigned                   chk_cnt = 0;
  int unsigned                   err_cnt = 0;
  int unsigned                   acc_cyc;
  int unsigned                   lat;
  int unsigned                   refills;
  int unsigned                   low_cnt;
  logic                          pend;
  logic                          seen;
  logic                          flush_arm;
  logic                          hold_q;
  logic [icache_pkg::ADDR_W-1:0] cur_addr;
  logic [icache_pkg::WORD_W-1:0] cur_exp;
  logic [icache_pkg::WORD_W-1:0] held_data;

  assign chk_cnt_o = chk_cnt;
  assign err_cnt_o = err_cnt;
  assign timeout_o = (cyc >= cycle_limit_i);

  task automatic flag(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  task automatic clear_model();
    for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
      kn_vld[s][0] = 1'b0;
      kn_vld[s][1] = 1'b0;
      set_full[s]  = 1'b0;
    end
  endtask

  // grade a delivered response, then update the resident model
  task automatic judge_response();
    icache_pkg::icache_addr_u     a;
    int                           s;
    int                           slot;
    logic [icache_pkg::TAG_W-1:0] t;
    logic                         known;
    logic                         certain;
    a.raw   = cur_addr;
    s       = int'(a.fields.index);
    t       = a.fields.tag;
    known   = (kn_vld[s][0] && kn_tag[s][0] == t) || (kn_vld[s][1] && kn_tag[s][1] == t);
    // absent for sure unless an unknown slot might hold it
    certain = !set_full[s] || (kn_vld[s][0] && kn_vld[s][1]);
    chk_cnt++;
    if (rsp_data_i !== cur_exp) begin
      flag($sformatf("FAILED rsp_data_o for addr %h: got %h, expected %h",
                     cur_addr, rsp_data_i, cur_exp));
    end
    if (known && refills != 0) begin
      flag($sformatf("resident line at addr %h was refilled", cur_addr));
    end
    if (!known && certain && refills == 0) begin
      flag($sformatf("line at addr %h cannot be resident but was not refilled", cur_addr));
    end
    if (refills > 1) begin
      flag($sformatf("fetch of addr %h sent %0d refill requests", cur_addr, refills));
    end
    // valid rises one cycle after the accepting edge and is seen one edge later
    if (refills == 0 && lat != 2) begin
      flag($sformatf("hit at addr %h answered %0d cycles after acceptance instead of 1",
                     cur_addr, lat - 1));
    end
    if (refills != 0 && set_full[s]) begin
      kn_tag[s][0] = t;
      kn_vld[s][0] = 1'b1;
      kn_vld[s][1] = 1'b0;
    end else if (!known) begin
      slot            = kn_vld[s][0] ? 1 : 0;
      kn_tag[s][slot] = t;
      kn_vld[s][slot] = 1'b1;
      set_full[s]     = kn_vld[s][0] && kn_vld[s][1];
    end
  endtask

  always @(posedge clk_i) begin
    cyc++;
    if (!rst_ni) begin
      pend      = 1'b0;
      seen      = 1'b0;
      hold_q    = 1'b0;
      flush_arm = 1'b1;
      low_cnt   = 0;
      clear_model();
    end else begin
      // flush sweep keeps ready low one cycle per set
      if (flush_arm) begin
        if (!req_ready_i) begin
          low_cnt++;
        end else begin
          if (low_cnt != icache_pkg::NUM_SETS) begin
            flag($sformatf("FAILED req_ready_o low for %h cycles, expected %h",
                           low_cnt, icache_pkg::NUM_SETS));
          end
          flush_arm = 1'b0;
        end
      end
      if (flush_i && !pend) begin
        flush_arm = 1'b1;
        low_cnt   = 0;
        clear_model();
      end
      if (miss_i !== (mem_req_valid_i && mem_req_ready_i)) begin
        flag($sformatf("FAILED miss_o: got %h, expected %h",
                       miss_i, mem_req_valid_i && mem_req_ready_i));
      end
      if (mem_req_valid_i && mem_req_ready_i) begin
        refills++;
        if (!pend) begin
          flag("refill request sent with no fetch open");
        end
        if (mem_req_addr_i !== {cur_addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                                {icache_pkg::OFFSET_W{1'b0}}}) begin
          flag($sformatf("FAILED mem_req_addr_o: got %h, fetch addr %h",
                         mem_req_addr_i, cur_addr));
        end
      end
      if (rsp_valid_i) begin
        if (!seen) begin
          lat  = cyc - acc_cyc;
          seen = 1'b1;
        end
        if (hold_q && rsp_data_i !== held_data) begin
          flag($sformatf("FAILED rsp_data_o changed under back-pressure: %h to %h",
                         held_data, rsp_data_i));
        end
        hold_q    = !rsp_ready_i;
        held_data = rsp_data_i;
        if (rsp_ready_i) begin
          if (!pend) begin
            flag("response delivered with no fetch open");
          end else begin
            judge_response();
          end
          pend = 1'b0;
        end
      end else begin
        if (hold_q) begin
          flag("rsp_valid_o dropped before the response was taken");
        end
        hold_q = 1'b0;
      end
      // no new fetch is taken until the open one is answered
      if (pend && req_ready_i) begin
        flag($sformatf("FAILED req_ready_o high while a fetch was open: got %h, expected %h",
                       req_ready_i, 1'b0));
      end
      if (req_valid_i && req_ready_i) begin
        pend     = 1'b1;
        seen     = 1'b0;
        refills  = 0;
        cur_addr = req_addr_i;
        cur_exp  = exp_word_i;
        acc_cyc  = cyc;
      end
    end
  end

endmodule

//--- verification/icache_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the two-way icache
// drives fetches on the falling edge, models the refill memory and
// hands the expected word of each request to the checker
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module icache_tb;

  // 24 + 4 + 6 + 3 + 24 fetches over the five tests
  localparam int NUM_REQ     = 61;
  localparam int CYCLE_LIMIT = 40 * NUM_REQ + 100;

  logic                                clk_i;
  logic                                rst_ni;
  logic                                flush_i;
  logic                                req_valid_i;
  logic [icache_pkg::ADDR_W-1:0]       req_addr_i;
  logic                                req_ready_o;
  logic                                rsp_valid_o;
  logic [icache_pkg::WORD_W-1:0]       rsp_data_o;
  logic                                rsp_ready_i;
  logic                                mem_req_valid_o;
  logic [icache_pkg::ADDR_W-1:0]       mem_req_addr_o;
  logic                                mem_req_ready_i;
  logic                                mem_rtrn_valid_i;
  logic [icache_pkg::LINE_W-1:0]       mem_rtrn_line_i;
  logic                                miss_o;
  logic [icache_pkg::WORD_W-1:0]       exp_word;
  int unsigned                         chk_cnt;
  int unsigned                         err_cnt;
  int unsigned                         last_chk;
  int unsigned                         last_err;
  logic                                timeout;
  logic                                bp_en;

  // memory word: upper half is the word address, lower half its inverse
  function automatic logic [icache_pkg::WORD_W-1:0] ref_word(
      input logic [icache_pkg::ADDR_W-1:0] addr);
    return {addr, ~addr};
  endfunction

  // word k of a line sits at bits 32k and up
  function automatic logic [icache_pkg::LINE_W-1:0] ref_line(
      input logic [icache_pkg::ADDR_W-1:0] line_addr);
    logic [icache_pkg::LINE_W-1:0] line;
    for (int k = 0; k < 4; k++) begin
      line[k*icache_pkg::WORD_W +: icache_pkg::WORD_W] = ref_word(line_addr + 16'(4 * k));
    end
    return line;
  endfunction

  // low two address bits are ignored by the cache
  assign exp_word = ref_word({req_addr_i[icache_pkg::ADDR_W-1:2], 2'b00});

  icache_top icache_top_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .req_valid_i      (req_valid_i),
    .req_addr_i       (req_addr_i),
    .req_ready_o      (req_ready_o),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_data_o       (rsp_data_o),
    .rsp_ready_i      (rsp_ready_i),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_rtrn_valid_i (mem_rtrn_valid_i),
    .mem_rtrn_line_i  (mem_rtrn_line_i),
    .miss_o           (miss_o)
  );

  icache_checker icache_checker_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .req_valid_i     (req_valid_i),
    .req_addr_i      (req_addr_i),
    .req_ready_i     (req_ready_o),
    .exp_word_i      (exp_word),
    .rsp_valid_i     (rsp_valid_o),
    .rsp_data_i      (rsp_data_o),
    .rsp_ready_i     (rsp_ready_i),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_addr_i  (mem_req_addr_o),
    .mem_req_ready_i (mem_req_ready_i),
    .miss_i          (miss_o),
    .cycle_limit_i   (CYCLE_LIMIT),
    .chk_cnt_o       (chk_cnt),
    .err_cnt_o       (err_cnt),
    .timeout_o       (timeout)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks, all entered and left on a falling edge
  //////////////////////////////////////////////////////////////////////

  // one fetch, waits for acceptance and for the delivered response
  task automatic fetch(input logic [icache_pkg::ADDR_W-1:0] addr);
    logic done;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    // ready only follows the state, so it is settled mid-cycle
    while (!req_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    req_valid_i = 1'b0;
    done        = 1'b0;
    while (!done) begin
      // back-pressure: ready one time in three
      rsp_ready_i = !bp_en || ($urandom_range(2, 0) == 0);
      done        = rsp_valid_o && rsp_ready_i;
      @(negedge clk_i);
    end
    rsp_ready_i = 1'b1;
  endtask

  task automatic fetch_random(input int n, input logic [icache_pkg::ADDR_W-1:0] mask);
    repeat (n) begin
      fetch(icache_pkg::ADDR_W'($urandom) & mask);
    end
  endtask

  // pulse in IDLE, then wait out the sweep
  task automatic pulse_flush();
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
  endtask

  task automatic close_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name,
             chk_cnt - last_chk, err_cnt - last_err);
    last_chk = chk_cnt;
    last_err = err_cnt;
  endtask

  task automatic end_run();
    $display("total: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0 && !timeout) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // memory model, single-beat line return without handshake
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [icache_pkg::ADDR_W-1:0] line_addr;
    forever begin
      @(negedge clk_i);
      if (mem_req_valid_o) begin
        // accept after 0 to 3 cycles
        repeat ($urandom_range(3, 0)) @(negedge clk_i);
        line_addr       = mem_req_addr_o;
        mem_req_ready_i = 1'b1;
        @(negedge clk_i);
        mem_req_ready_i = 1'b0;
        // return lands 2 to 5 cycles after the handshake edge
        repeat ($urandom_range(4, 1)) @(negedge clk_i);
        mem_rtrn_line_i  = ref_line(line_addr);
        mem_rtrn_valid_i = 1'b1;
        @(negedge clk_i);
        mem_rtrn_valid_i = 1'b0;
      end
    end
  end

  initial begin
    @(posedge timeout);
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    end_run();
  end

  initial begin
    void'($urandom(9672));
    rst_ni           = 1'b0;
    flush_i          = 1'b0;
    req_valid_i      = 1'b0;
    req_addr_i       = '0;
    rsp_ready_i      = 1'b1;
    mem_req_ready_i  = 1'b0;
    mem_rtrn_valid_i = 1'b0;
    mem_rtrn_line_i  = '0;
    bp_en            = 1'b0;
    last_chk         = 0;
    last_err         = 0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    // 64 lines over 16 sets, hits and random evictions mixed
    fetch_random(24, 16'h03ff);
    close_test(1, "reset_and_random");

    // fresh line, first word misses, the rest of the line hits
    pulse_flush();
    for (int k = 0; k < 4; k++) begin
      fetch(16'h1000 + 16'(4 * k));
    end
    close_test(2, "first_access_and_repeat");

    // set 3: two tags stay, a third one evicts one at random
    fetch(16'h2030);
    fetch(16'h3030);
    fetch(16'h2034);
    fetch(16'h3038);
    fetch(16'h4030);
    fetch(16'h4034);
    close_test(3, "two_tags_one_set");

    pulse_flush();
    fetch(16'h1000);
    fetch(16'h3030);
    fetch(16'h4034);
    close_test(4, "flush_then_refetch");

    bp_en = 1'b1;
    fetch_random(24, 16'h01ff);
    bp_en = 1'b0;
    close_test(5, "backpressure");

    end_run();
  end

endmodule

//--- verilog.f
common/icache_pkg.sv
icache/icache_tag_array.sv
icache/icache_data_array.sv
icache/icache_ctrl.sv
design/icache_top.sv
verification/icache_checker.sv
verification/icache_tb.sv

//--- Makefile
# Verilator build and run of the icache testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, pass only if the log holds the pass message"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal --top-module icache_tb -f verilog.f -Mdir obj_dir
	./obj_dir/Vicache_tb | tee $(LOG)
	grep -q "^All checks passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
